// ==== hw/blink_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module blink_sequencer (
    input  logic                        clk_1,
    input  logic                        reset,
    input  logic                        step_tick,
    output pin_finder_pkg::blink_state_t state,
    output logic                        frame_done
);

    pin_finder_pkg::blink_phase_t next_phase;
    logic                         at_end;
    logic                         in_field;

    // number of slots or steps in each phase
    function automatic int slot_limit(input pin_finder_pkg::blink_phase_t phase);
        int limit;
        case (phase)
            pin_finder_pkg::row_field: limit = pin_finder_pkg::row_slots;
            pin_finder_pkg::gap:       limit = pin_finder_pkg::gap_steps;
            pin_finder_pkg::col_field: limit = pin_finder_pkg::col_slots;
            default:                   limit = pin_finder_pkg::rest_steps;
        endcase
        return limit;
    endfunction

    always_comb begin
        at_end = state.slot == 5'(slot_limit(state.phase) - 1);
        in_field = (state.phase == pin_finder_pkg::row_field) ||
                   (state.phase == pin_finder_pkg::col_field);
        // rest wraps back to the row field
        case (state.phase)
            pin_finder_pkg::row_field: next_phase = pin_finder_pkg::gap;
            pin_finder_pkg::gap:       next_phase = pin_finder_pkg::col_field;
            pin_finder_pkg::col_field: next_phase = pin_finder_pkg::rest;
            default:                   next_phase = pin_finder_pkg::row_field;
        endcase
    end

    always_ff @(posedge clk_1) begin
        if (reset) begin
            // park on the last rest step, all dark
            state <= '{
                phase: pin_finder_pkg::rest,
                slot: 5'(pin_finder_pkg::rest_steps - 1),
                lit: 1'b0
            };
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (step_tick) begin
                if (state.lit) begin
                    // second half of a pulse is dark
                    state.lit <= 1'b0;
                end else if (!at_end) begin
                    state.slot <= state.slot + 5'd1;
                    // gap and rest never light
                    state.lit <= in_field;
                end else begin
                    state.phase <= next_phase;
                    state.slot <= '0;
                    state.lit <= (next_phase == pin_finder_pkg::row_field) ||
                                 (next_phase == pin_finder_pkg::col_field);
                    // leaving rest closes the frame
                    frame_done <= state.phase == pin_finder_pkg::rest;
                end
            end
        end
    end

    slot_in_range: assert property (@(posedge clk_1) disable iff (reset)
        int'(state.slot) < slot_limit(state.phase));

endmodule

`default_nettype wire

// ==== hw/digit_source.sv ====
`timescale 1ns/1ns
`default_nettype none

module digit_source (
    input  logic                    clk_1,
    input  logic                    reset,
    input  logic                    frame_done,
    input  logic                    credit_return,
    output pin_finder_pkg::tx_byte_t byte_out
);

    typedef logic [$clog2(pin_finder_pkg::tx_depth + 1)-1:0] credit_t;

    credit_t    credits;
    logic [7:0] digit;
    logic       spend;
    logic       out_valid;
    logic [7:0] out_data;

    // a frame without a free credit is simply dropped
    assign spend = frame_done && (credits != '0);

    always_ff @(posedge clk_1) begin
        if (reset) begin
            credits <= credit_t'(pin_finder_pkg::tx_depth);
            digit <= pin_finder_pkg::ascii_zero;
            out_valid <= 1'b0;
        end else begin
            out_valid <= spend;
            if (spend) begin
                // '9' wraps to '0'
                digit <= (digit == pin_finder_pkg::ascii_nine) ?
                         pin_finder_pkg::ascii_zero : digit + 8'd1;
            end
            // spend and return in the same cycle cancel out
            if (spend && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (credit_return && !spend) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_1) begin
        if (spend) begin
            out_data <= digit;
        end
    end

    assign byte_out = '{valid: out_valid, data: out_data};

    valid_needs_credit: assert property (@(posedge clk_1) disable iff (reset)
        byte_out.valid |-> $past(credits) != '0);

    credits_bounded: assert property (@(posedge clk_1) disable iff (reset)
        credits <= credit_t'(pin_finder_pkg::tx_depth));

endmodule

`default_nettype wire

// ==== hw/led_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_bank (
    input  logic                                clk_1,
    input  logic                                reset,
    input  pin_finder_pkg::blink_state_t        state,
    output logic [pin_finder_pkg::pin_count-1:0] led
);

    logic [pin_finder_pkg::pin_count-1:0] active;
    logic [pin_finder_pkg::pin_count-1:0] polarity;

    // pin is on while lit and the slot is below its row or column number
    always_comb begin
        for (int i = 0; i < pin_finder_pkg::pin_count; i++) begin
            polarity[i] = pin_finder_pkg::pin_table[i].active_low;
            case (state.phase)
                pin_finder_pkg::row_field:
                    active[i] = state.lit &&
                                (state.slot < pin_finder_pkg::pin_table[i].row);
                pin_finder_pkg::col_field:
                    active[i] = state.lit &&
                                (state.slot < pin_finder_pkg::pin_table[i].col);
                default:
                    active[i] = 1'b0;
            endcase
        end
    end

    // inactive level is the polarity bit itself
    always_ff @(posedge clk_1) begin
        if (reset) begin
            led <= polarity;
        end else begin
            led <= active ^ polarity;
        end
    end

endmodule

`default_nettype wire

// ==== hw/pin_finder_pkg.sv ====
`default_nettype none

package pin_finder_pkg;

    // number of LED pins driven by the design
    localparam int pin_count = 8;

    // 25 MHz board clock, one blink step every 100 ms
    localparam int default_clocks_per_step = 2_500_000;
    // 25 MHz divided down to 9600 baud
    localparam int default_clocks_per_bit = 25_000_000 / 9600;

    // frame layout in step ticks
    // row and column fields use two steps per pulse slot
    localparam int row_slots = 20;
    localparam int col_slots = 16;
    localparam int gap_steps = 4;
    localparam int rest_steps = 4;

    // bounds of the transmitted digit stream
    localparam logic [7:0] ascii_zero = 8'd48;
    localparam logic [7:0] ascii_nine = 8'd57;

    // uart buffer entries, also the credits held by the digit source
    localparam int tx_depth = 2;

    // frame phases in the order they are walked
    typedef enum logic [1:0] {
        row_field,
        gap,
        col_field,
        rest
    } blink_phase_t;

    // shared blink position, 8 bits
    typedef struct packed {
        blink_phase_t phase;
        // pulse index in a field, step index in gap or rest
        logic [4:0]   slot;
        // on-half of the current pulse
        logic         lit;
    } blink_state_t;

    // ball coordinate of one LED pin, 11 bits
    typedef struct packed {
        // ball row letter as a number, A=1 through T=20
        logic [4:0] row;
        logic [4:0] col;
        // pin drives its LED low when on
        logic       active_low;
    } pin_entry_t;

    // representative pins, index i drives led[i]
    localparam pin_entry_t pin_table [pin_count] = '{
        '{row: 5'd2,  col: 5'd1,  active_low: 1'b0},
        '{row: 5'd3,  col: 5'd4,  active_low: 1'b0},
        '{row: 5'd4,  col: 5'd3,  active_low: 1'b0},
        '{row: 5'd5,  col: 5'd16, active_low: 1'b0},
        '{row: 5'd8,  col: 5'd12, active_low: 1'b0},
        '{row: 5'd13, col: 5'd7,  active_low: 1'b0},
        '{row: 5'd16, col: 5'd14, active_low: 1'b0},
        // T6 is the on-board LED, low-active
        '{row: 5'd20, col: 5'd6,  active_low: 1'b1}
    };

    // one byte offered to the uart, 9 bits
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } tx_byte_t;

endpackage

`default_nettype wire

// ==== hw/pin_finder_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pin_finder_top #(
    parameter int clocks_per_step = pin_finder_pkg::default_clocks_per_step,
    parameter int clocks_per_bit = pin_finder_pkg::default_clocks_per_bit
) (
    input  logic                                clk_1,
    input  logic                                reset,
    output logic [pin_finder_pkg::pin_count-1:0] led,
    output logic                                txd
);

    logic                         step_tick;
    logic                         bit_tick;
    pin_finder_pkg::blink_state_t blink_state;
    logic                         frame_done;
    pin_finder_pkg::tx_byte_t     tx_byte;
    logic                         credit_return;

    // enables for the blink and uart rates
    tick_gen #(
        .clocks_per_step(clocks_per_step),
        .clocks_per_bit(clocks_per_bit)
    ) tick_gen_inst (
        .clk_1(clk_1),
        .reset(reset),
        .step_tick(step_tick),
        .bit_tick(bit_tick)
    );

    // one shared frame walker for all pins
    blink_sequencer blink_sequencer_inst (
        .clk_1(clk_1),
        .reset(reset),
        .step_tick(step_tick),
        .state(blink_state),
        .frame_done(frame_done)
    );

    led_bank led_bank_inst (
        .clk_1(clk_1),
        .reset(reset),
        .state(blink_state),
        .led(led)
    );

    // one digit per frame, credit limited
    digit_source digit_source_inst (
        .clk_1(clk_1),
        .reset(reset),
        .frame_done(frame_done),
        .credit_return(credit_return),
        .byte_out(tx_byte)
    );

    uart_tx uart_tx_inst (
        .clk_1(clk_1),
        .reset(reset),
        .bit_tick(bit_tick),
        .byte_in(tx_byte),
        .credit_return(credit_return),
        .txd(txd)
    );

endmodule

`default_nettype wire

// ==== hw/tick_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
    parameter int clocks_per_step = pin_finder_pkg::default_clocks_per_step,
    parameter int clocks_per_bit = pin_finder_pkg::default_clocks_per_bit
) (
    input  logic clk_1,
    input  logic reset,
    output logic step_tick,
    output logic bit_tick
);

    typedef logic [$clog2(clocks_per_step)-1:0] step_count_t;
    typedef logic [$clog2(clocks_per_bit)-1:0] bit_count_t;

    step_count_t step_count;
    bit_count_t  bit_count;

    // blink step enable
    // registered so the first pulse lands N cycles after reset
    always_ff @(posedge clk_1) begin
        if (reset) begin
            step_count <= '0;
            step_tick <= 1'b0;
        end else if (step_count == step_count_t'(clocks_per_step - 1)) begin
            step_count <= '0;
            step_tick <= 1'b1;
        end else begin
            step_count <= step_count + 1'b1;
            step_tick <= 1'b0;
        end
    end

    // uart bit enable, same scheme at the bit rate
    always_ff @(posedge clk_1) begin
        if (reset) begin
            bit_count <= '0;
            bit_tick <= 1'b0;
        end else if (bit_count == bit_count_t'(clocks_per_bit - 1)) begin
            bit_count <= '0;
            bit_tick <= 1'b1;
        end else begin
            bit_count <= bit_count + 1'b1;
            bit_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic                    clk_1,
    input  logic                    reset,
    input  logic                    bit_tick,
    input  pin_finder_pkg::tx_byte_t byte_in,
    output logic                    credit_return,
    output logic                    txd
);

    // what the line is carrying right now
    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    typedef logic [$clog2(pin_finder_pkg::tx_depth)-1:0] ptr_t;
    typedef logic [$clog2(pin_finder_pkg::tx_depth + 1)-1:0] count_t;

    logic [7:0] fifo_mem [pin_finder_pkg::tx_depth];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    count_t     count;
    logic       pop;
    tx_state_t  tx_state;
    logic [7:0] shift;
    logic [2:0] bit_index;

    // next byte leaves the buffer on a tick from idle or at the end of a stop bit
    assign pop = bit_tick && (count != '0) &&
                 ((tx_state == tx_idle) || (tx_state == tx_stop));

    // buffer storage
    always_ff @(posedge clk_1) begin
        if (byte_in.valid) begin
            fifo_mem[wr_ptr] <= byte_in.data;
        end
    end

    // buffer pointers and fill level
    always_ff @(posedge clk_1) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (byte_in.valid) begin
                wr_ptr <= (wr_ptr == ptr_t'(pin_finder_pkg::tx_depth - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(pin_finder_pkg::tx_depth - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            if (byte_in.valid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !byte_in.valid) begin
                count <= count - 1'b1;
            end
        end
    end

    // 8N1 serializer, lsb first
    always_ff @(posedge clk_1) begin
        if (reset) begin
            tx_state <= tx_idle;
            txd <= 1'b1;
            bit_index <= 3'd0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= 1'b0;
            if (bit_tick) begin
                case (tx_state)
                    tx_start: begin
                        txd <= shift[0];
                        shift <= shift >> 1;
                        bit_index <= 3'd0;
                        tx_state <= tx_data;
                    end
                    tx_data: begin
                        if (bit_index == 3'd7) begin
                            txd <= 1'b1;
                            tx_state <= tx_stop;
                        end else begin
                            txd <= shift[0];
                            shift <= shift >> 1;
                            bit_index <= bit_index + 3'd1;
                        end
                    end
                    default: begin
                        // stop bit done, hand the slot back
                        credit_return <= tx_state == tx_stop;
                        if (pop) begin
                            // start bit of the next byte
                            txd <= 1'b0;
                            shift <= fifo_mem[rd_ptr];
                            tx_state <= tx_start;
                        end else begin
                            txd <= 1'b1;
                            tx_state <= tx_idle;
                        end
                    end
                endcase
            end
        end
    end

    // credit flow upstream must keep the buffer from overflowing
    no_write_when_full: assert property (@(posedge clk_1) disable iff (reset)
        byte_in.valid |-> count != count_t'(pin_finder_pkg::tx_depth));

endmodule

`default_nettype wire

// ==== pin_finder.f ====
hw/pin_finder_pkg.sv
hw/tick_gen.sv
hw/blink_sequencer.sv
hw/led_bank.sv
hw/digit_source.sv
hw/uart_tx.sv
hw/pin_finder_top.sv
testbench/pin_finder_tb.sv

// ==== testbench/pin_finder_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pin_finder_tb;

    // fast rates, a frame is 320 cycles and a byte 480, so frames outrun the uart
    localparam int step_clocks = 4;
    localparam int bit_clocks = 48;
    localparam int frame_clocks = 80 * step_clocks;
    localparam int byte_clocks = 10 * bit_clocks;
    localparam int pins = pin_finder_pkg::pin_count;
    localparam int run_count = 4;

    logic            clk_1;
    logic            reset;
    logic [pins-1:0] led;
    logic            txd;
    logic [15:0]     lfsr_state;
    int              tests_run;
    int              tests_bad;

    // led decoder, one entry per pin
    int   on_run [pins];
    int   dark_run [pins];
    int   pulses [pins];
    int   groups [pins];
    logic expect_row [pins];
    int   group_errors;
    int   polarity_errors;

    // uart decoder
    logic       rx_busy;
    int         rx_count;
    logic [9:0] rx_bits;
    logic [7:0] next_digit;
    int         bytes_seen;
    int         framing_errors;
    int         digit_errors;

    pin_finder_top #(
        .clocks_per_step(step_clocks),
        .clocks_per_bit(bit_clocks)
    ) pin_finder_top_inst (
        .clk_1(clk_1),
        .reset(reset),
        .led(led),
        .txd(txd)
    );

    always #5 clk_1 = ~clk_1;

    // ball row or column of each pin, B1 C4 D3 E16 H12 M7 P14 T6
    function automatic int group_size(input int pin, input logic row_group);
        case (pin)
            0: return row_group ? 2 : 1;
            1: return row_group ? 3 : 4;
            2: return row_group ? 4 : 3;
            3: return row_group ? 5 : 16;
            4: return row_group ? 8 : 12;
            5: return row_group ? 13 : 7;
            6: return row_group ? 16 : 14;
            default: return row_group ? 20 : 6;
        endcase
    endfunction

    // only T6 is low-active, so it idles high
    function automatic logic idle_level(input int pin);
        return pin == 7;
    endfunction

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // one lfsr step per bit, msb first
    task automatic take_random_bits(input int width, output int value);
        value = 0;
        for (int b = 0; b < width; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // called on a falling edge, holds reset for three rising edges
    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(negedge clk_1);
        reset = 1'b0;
    endtask

    task automatic report_test(input string name, input int run, input int errors);
        tests_run++;
        if (errors == 0) begin
            $display("test %s run %0d: ok", name, run);
        end else begin
            tests_bad++;
            $display("test %s run %0d: %0d errors", name, run, errors);
        end
    endtask

    // counts pulses per pin, three dark steps close a group
    always @(posedge clk_1) begin : led_decode
        int expected;
        if (reset) begin
            for (int i = 0; i < pins; i++) begin
                on_run[i] = 0;
                dark_run[i] = 0;
                pulses[i] = 0;
                groups[i] = 0;
                // every frame opens with the row group
                expect_row[i] = 1'b1;
            end
            group_errors = 0;
            polarity_errors = 0;
        end else begin
            for (int i = 0; i < pins; i++) begin
                if (led[i] !== idle_level(i)) begin
                    if (on_run[i] == 0) begin
                        pulses[i]++;
                    end
                    on_run[i]++;
                    dark_run[i] = 0;
                end else begin
                    // a pulse is active for one step, a flipped pin looks long
                    if (on_run[i] != 0 && on_run[i] != step_clocks) begin
                        $display("Mismatch led_polarity pin %0d: expected %0d, actual %0d",
                                 i, step_clocks, on_run[i]);
                        polarity_errors++;
                    end
                    on_run[i] = 0;
                    dark_run[i]++;
                    if (dark_run[i] == 3 * step_clocks && pulses[i] != 0) begin
                        expected = group_size(i, expect_row[i]);
                        if (pulses[i] != expected) begin
                            $display("Mismatch led_groups pin %0d: expected %0d, actual %0d",
                                     i, expected, pulses[i]);
                            group_errors++;
                        end
                        // row and column groups alternate
                        expect_row[i] = !expect_row[i];
                        groups[i]++;
                        pulses[i] = 0;
                    end
                end
            end
        end
    end

    // 8N1 receiver, sampled at mid-bit
    always @(posedge clk_1) begin : uart_decode
        logic [7:0] data;
        if (reset) begin
            rx_busy = 1'b0;
            rx_count = 0;
            bytes_seen = 0;
            // first digit after reset is '0'
            next_digit = 8'h30;
            framing_errors = 0;
            digit_errors = 0;
        end else if (!rx_busy) begin
            if (txd === 1'b0) begin
                rx_busy = 1'b1;
                rx_count = 0;
            end
        end else begin
            rx_count++;
            if (rx_count % bit_clocks == bit_clocks / 2) begin
                rx_bits[rx_count / bit_clocks] = txd;
            end
            // middle of the stop bit ends the byte
            if (rx_count == 9 * bit_clocks + bit_clocks / 2) begin
                rx_busy = 1'b0;
                data = rx_bits[8:1];
                // start then stop bit, shown as one pair
                if (rx_bits[0] !== 1'b0 || rx_bits[9] !== 1'b1) begin
                    $display("Mismatch uart_framing byte %0d: expected 01, actual %b%b",
                             bytes_seen, rx_bits[0], rx_bits[9]);
                    framing_errors++;
                end
                if (data !== next_digit) begin
                    $display("Mismatch digit_sequence byte %0d: expected %02h, actual %02h",
                             bytes_seen, next_digit, data);
                    digit_errors++;
                end
                // expected stream counts up from '0' and wraps after '9'
                next_digit = (next_digit == 8'h39) ? 8'h30 : next_digit + 8'd1;
                bytes_seen++;
            end
        end
    end

    initial begin : main
        int              run;
        int              target;
        int              value;
        int              errors;
        int              cycles;
        logic            timed_out;
        logic [pins-1:0] idle_leds;
        clk_1 = 1'b0;
        reset = 1'b1;
        lfsr_state = 16'd24;
        tests_run = 0;
        tests_bad = 0;
        timed_out = 1'b0;
        for (int i = 0; i < pins; i++) begin
            idle_leds[i] = idle_level(i);
        end
        for (run = 0; run < run_count && !timed_out; run++) begin
            // long first run reaches back-pressure, later runs are short and random
            target = 12;
            if (run != 0) begin
                take_random_bits(2, value);
                target = 1 + value;
            end
            apply_reset();
            // first cycle out of reset
            @(negedge clk_1);
            errors = 0;
            if (txd !== 1'b1) begin
                $display("Mismatch reset_levels txd: expected 1, actual %b", txd);
                errors++;
            end
            if (led !== idle_leds) begin
                $display("Mismatch reset_levels led: expected %b, actual %b", idle_leds, led);
                errors++;
            end
            report_test("reset_levels", run, errors);
            cycles = 0;
            while (bytes_seen < target &&
                   cycles < (target + 1) * byte_clocks + 2 * frame_clocks) begin
                @(negedge clk_1);
                cycles++;
            end
            if (bytes_seen < target) begin
                $display("timeout: run %0d received %0d of %0d bytes", run, bytes_seen, target);
                timed_out = 1'b1;
            end else begin
                // next reset lands at a random point of the frame and byte
                take_random_bits(8, value);
                repeat (value) @(negedge clk_1);
                errors = group_errors;
                for (int i = 0; i < pins; i++) begin
                    if (groups[i] < 2) begin
                        $display("led_groups: pin %0d never finished a row and a column group", i);
                        errors++;
                    end
                end
                report_test("led_groups", run, errors);
                report_test("led_polarity", run, polarity_errors);
                report_test("uart_framing", run, framing_errors);
                report_test("digit_sequence", run, digit_errors);
            end
        end
        $display("summary: %0d tests run, %0d with errors", tests_run, tests_bad);
        if (tests_bad == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
